/* rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
  typedef logic [31:0] instr_t;

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_src_t;

  // ALU funct3 codes, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Word access for LW and SW
  localparam logic [2:0] F3_WORD = 3'b010;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  localparam word_t RESET_PC = '0;

  // ADDI x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

/* mem_port_if.sv */
interface mem_port_if import rv_pkg::*; ();
  word_t addr;
  logic  rd_en;
  logic  wr_en;
  word_t wr_data;
  logic  grant;
  logic  rd_valid;
  word_t rd_data;

  modport requester (
    output addr, rd_en, wr_en, wr_data,
    input  grant, rd_valid, rd_data
  );

  modport arbiter (
    input  addr, rd_en, wr_en, wr_data,
    output grant, rd_valid, rd_data
  );
endinterface

/* pipe_if.sv */
interface id_ex_if import rv_pkg::*; ();
  logic      valid;
  word_t     pc;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd;
  word_t     imm;
  alu_op_t   alu_op;
  logic      use_imm, is_load, is_store, is_branch, branch_ne, is_jal, wb_en;

  modport source (output valid, pc, rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op,
                  use_imm, is_load, is_store, is_branch, branch_ne, is_jal, wb_en);
  modport sink (input valid, pc, rs1, rs2, rs1_data, rs2_data, rd, imm, alu_op,
                use_imm, is_load, is_store, is_branch, branch_ne, is_jal, wb_en);
endinterface

interface ex_mem_if import rv_pkg::*; ();
  logic      valid;
  reg_addr_t rd;
  word_t     result;
  word_t     store_data;
  logic      is_load, is_store, wb_en;

  modport source (output valid, rd, result, store_data, is_load, is_store, wb_en);
  modport sink (input valid, rd, result, store_data, is_load, is_store, wb_en);
endinterface

/* mem_arbiter.sv */
module mem_arbiter import rv_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  mem_port_if.arbiter   fetch_port,
  mem_port_if.arbiter   data_port,
  output word_t         mem_addr,
  output logic          mem_rd_en,
  output logic          mem_wr_en,
  output word_t         mem_wr_data,
  input  word_t         mem_rd_data
);

  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_FETCH,
    OWNER_DATA
  } owner_t;

  owner_t owner_q;
  logic   data_req;
  logic   fetch_req;

  assign data_req = data_port.rd_en | data_port.wr_en;
  assign fetch_req = fetch_port.rd_en | fetch_port.wr_en;

  // Data access always wins
  assign data_port.grant = data_req;
  assign fetch_port.grant = fetch_req & ~data_req;

  assign mem_addr = data_req ? data_port.addr : fetch_port.addr;
  assign mem_rd_en = data_req ? data_port.rd_en : fetch_port.rd_en;
  assign mem_wr_en = data_req ? data_port.wr_en : fetch_port.wr_en;
  assign mem_wr_data = data_req ? data_port.wr_data : fetch_port.wr_data;

  // Owner of the read answered in the next cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      owner_q <= OWNER_NONE;
    end else if (mem_rd_en) begin
      owner_q <= data_req ? OWNER_DATA : OWNER_FETCH;
    end else begin
      owner_q <= OWNER_NONE;
    end
  end

  assign data_port.rd_valid = (owner_q == OWNER_DATA);
  assign fetch_port.rd_valid = (owner_q == OWNER_FETCH);
  assign data_port.rd_data = mem_rd_data;
  assign fetch_port.rd_data = mem_rd_data;

endmodule

/* fetch_stage.sv */
module fetch_stage import rv_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  mem_port_if.requester  mem,
  input  logic           stall,
  input  logic           redirect,
  input  word_t          redirect_pc,
  output instr_t         instr,
  output word_t          pc,
  output logic           instr_valid
);

  word_t pc_q;
  word_t req_pc_q;
  word_t req_addr;
  logic  replay;

  // A response that lands during a stall is lost and must be fetched again
  assign replay = mem.rd_valid & stall & ~redirect;
  assign req_addr = replay ? req_pc_q : pc_q;

  assign mem.addr = req_addr;
  assign mem.rd_en = ~redirect;
  assign mem.wr_en = 1'b0;
  assign mem.wr_data = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= RESET_PC;
    end else if (redirect) begin
      pc_q <= redirect_pc;
    end else if (mem.grant) begin
      pc_q <= req_addr + word_t'(4);
    end else if (replay) begin
      pc_q <= req_pc_q;
    end
  end

  always_ff @(posedge clock) begin
    if (mem.grant) begin
      req_pc_q <= req_addr;
    end
  end

  // Fetch/decode register
  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      instr <= NOP_INSTR;
      instr_valid <= 1'b0;
    end else if (!stall) begin
      instr <= mem.rd_valid ? mem.rd_data : NOP_INSTR;
      instr_valid <= mem.rd_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      pc <= req_pc_q;
    end
  end

endmodule

/* reg_file.sv */
module reg_file import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data
);

  word_t regs [REG_COUNT];

  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    // Same-cycle write bypass
    if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* decode_stage.sv */
module decode_stage import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  instr_t    instr,
  input  word_t     pc,
  input  logic      instr_valid,
  input  logic      redirect,
  input  logic      wb_en,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output logic      stall,
  id_ex_if.source   id_ex
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      imm_i, imm_s, imm_b, imm_j;
  word_t      imm;
  alu_op_t    alu_op;
  logic       alu_known;
  logic       op_legal;
  logic       use_imm, is_load, is_store, is_branch, is_jal, writes_rd;
  logic       uses_rs1, uses_rs2;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign rd_addr = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_known = 1'b1;
    case (funct3)
      F3_ADD_SUB: alu_op = (opcode == OP && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
      F3_SLT:     alu_op = ALU_SLT;
      F3_XOR:     alu_op = ALU_XOR;
      F3_OR:      alu_op = ALU_OR;
      F3_AND:     alu_op = ALU_AND;
      default: begin
        alu_op = ALU_ADD;
        alu_known = 1'b0;
      end
    endcase
    // Loads and stores add the offset to the base
    if (opcode != OP && opcode != OP_IMM) begin
      alu_op = ALU_ADD;
    end
  end

  // SUB is the only OP encoding with a non-zero funct7
  assign op_legal = alu_known &&
                    (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD_SUB));

  // Unsupported encodings fall through as no-ops
  always_comb begin
    imm = imm_i;
    use_imm = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    writes_rd = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OP: begin
        writes_rd = op_legal;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_IMM: begin
        writes_rd = alu_known;
        use_imm = 1'b1;
        uses_rs1 = 1'b1;
      end
      LOAD: begin
        is_load = (funct3 == F3_WORD);
        writes_rd = is_load;
        use_imm = 1'b1;
        uses_rs1 = 1'b1;
      end
      STORE: begin
        imm = imm_s;
        is_store = (funct3 == F3_WORD);
        use_imm = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      BRANCH: begin
        imm = imm_b;
        is_branch = (funct3 == F3_BEQ || funct3 == F3_BNE);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      JAL: begin
        imm = imm_j;
        is_jal = 1'b1;
        writes_rd = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Load in execute feeding this instruction
  assign stall = instr_valid && id_ex.valid && id_ex.is_load && id_ex.rd != '0 &&
                 ((uses_rs1 && rs1_addr == id_ex.rd) || (uses_rs2 && rs2_addr == id_ex.rd));

  reg_file regs (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1_addr),
    .rs2      (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_en),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data)
  );

  always_ff @(posedge clock) begin
    if (reset || redirect || stall) begin
      id_ex.valid <= 1'b0;
      id_ex.is_load <= 1'b0;
      id_ex.is_store <= 1'b0;
      id_ex.is_branch <= 1'b0;
      id_ex.is_jal <= 1'b0;
      id_ex.wb_en <= 1'b0;
    end else begin
      id_ex.valid <= instr_valid;
      id_ex.is_load <= is_load;
      id_ex.is_store <= is_store;
      id_ex.is_branch <= is_branch;
      id_ex.is_jal <= is_jal;
      id_ex.wb_en <= writes_rd;
    end
  end

  always_ff @(posedge clock) begin
    id_ex.pc <= pc;
    id_ex.rs1 <= rs1_addr;
    id_ex.rs2 <= rs2_addr;
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.rd <= rd_addr;
    id_ex.imm <= imm;
    id_ex.alu_op <= alu_op;
    id_ex.use_imm <= use_imm;
    id_ex.branch_ne <= (funct3 == F3_BNE);
  end

endmodule

/* execute_stage.sv */
module execute_stage import rv_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  id_ex_if.sink     id_ex,
  input  logic      mem_fwd_en,
  input  reg_addr_t mem_fwd_rd,
  input  word_t     mem_fwd_data,
  input  logic      wb_en,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  output logic      redirect,
  output word_t     redirect_pc,
  ex_mem_if.source  ex_mem
);

  word_t   op_a;
  word_t   op_b;
  word_t   alu_b;
  word_t   alu_y;
  word_t   link;
  word_t   result;
  wb_src_t res_src;
  logic    taken;

  // Youngest producer wins
  function automatic word_t forward(input reg_addr_t src, input word_t reg_value);
    if (src == '0) begin
      return reg_value;
    end
    if (mem_fwd_en && mem_fwd_rd == src) begin
      return mem_fwd_data;
    end
    if (wb_en && wb_rd == src) begin
      return wb_data;
    end
    return reg_value;
  endfunction

  always_comb begin
    op_a = forward(id_ex.rs1, id_ex.rs1_data);
    op_b = forward(id_ex.rs2, id_ex.rs2_data);
  end

  assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.alu_op)
      ALU_SUB: alu_y = op_a - alu_b;
      ALU_AND: alu_y = op_a & alu_b;
      ALU_OR:  alu_y = op_a | alu_b;
      ALU_XOR: alu_y = op_a ^ alu_b;
      ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_y = op_a + alu_b;
    endcase
  end

  assign taken = id_ex.valid &&
                 (id_ex.is_jal || (id_ex.is_branch && ((op_a == op_b) ^ id_ex.branch_ne)));
  assign redirect = taken;
  assign redirect_pc = id_ex.pc + id_ex.imm;

  assign link = id_ex.pc + word_t'(4);
  assign res_src = id_ex.is_jal ? WB_LINK : WB_ALU;
  assign result = (res_src == WB_LINK) ? link : alu_y;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
      ex_mem.is_load <= 1'b0;
      ex_mem.is_store <= 1'b0;
      ex_mem.wb_en <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.is_load <= id_ex.valid & id_ex.is_load;
      ex_mem.is_store <= id_ex.valid & id_ex.is_store;
      ex_mem.wb_en <= id_ex.valid & id_ex.wb_en;
    end
  end

  always_ff @(posedge clock) begin
    ex_mem.rd <= id_ex.rd;
    ex_mem.result <= result;
    ex_mem.store_data <= op_b;
  end

endmodule

/* memory_stage.sv */
module memory_stage import rv_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  ex_mem_if.sink         ex_mem,
  mem_port_if.requester  mem,
  output logic           mem_fwd_en,
  output reg_addr_t      mem_fwd_rd,
  output word_t          mem_fwd_data,
  output logic           wb_en,
  output reg_addr_t      wb_rd,
  output word_t          wb_data
);

  logic      wb_en_q;
  wb_src_t   wb_src_q;
  reg_addr_t rd_q;
  word_t     result_q;

  assign mem.addr = ex_mem.result;
  assign mem.rd_en = ex_mem.valid & ex_mem.is_load;
  assign mem.wr_en = ex_mem.valid & ex_mem.is_store;
  assign mem.wr_data = ex_mem.store_data;

  // Load data is not ready until writeback
  assign mem_fwd_en = ex_mem.valid & ex_mem.wb_en & ~ex_mem.is_load;
  assign mem_fwd_rd = ex_mem.rd;
  assign mem_fwd_data = ex_mem.result;

  // Memory/writeback register
  always_ff @(posedge clock) begin
    if (reset) begin
      wb_en_q <= 1'b0;
      wb_src_q <= WB_ALU;
    end else begin
      wb_en_q <= ex_mem.valid & ex_mem.wb_en;
      wb_src_q <= (mem.rd_en && mem.grant) ? WB_LOAD : WB_ALU;
    end
  end

  always_ff @(posedge clock) begin
    rd_q <= ex_mem.rd;
    result_q <= ex_mem.result;
  end

  // A load writes only once its data has come back
  assign wb_en = wb_en_q & ((wb_src_q != WB_LOAD) | mem.rd_valid);
  assign wb_rd = rd_q;
  assign wb_data = (wb_src_q == WB_LOAD) ? mem.rd_data : result_q;

endmodule

/* rv_core.sv */
module rv_core import rv_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  output word_t mem_addr,
  output logic  mem_rd_en,
  output logic  mem_wr_en,
  output word_t mem_wr_data,
  input  word_t mem_rd_data
);

  mem_port_if fetch_mem ();
  mem_port_if data_mem ();
  id_ex_if    id_ex ();
  ex_mem_if   ex_mem ();

  logic      stall;
  logic      redirect;
  word_t     redirect_pc;
  instr_t    instr;
  word_t     pc;
  logic      instr_valid;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      mem_fwd_en;
  reg_addr_t mem_fwd_rd;
  word_t     mem_fwd_data;

  fetch_stage fetch (
    .clock       (clock),
    .reset       (reset),
    .mem         (fetch_mem.requester),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr       (instr),
    .pc          (pc),
    .instr_valid (instr_valid)
  );

  decode_stage decode (
    .clock       (clock),
    .reset       (reset),
    .instr       (instr),
    .pc          (pc),
    .instr_valid (instr_valid),
    .redirect    (redirect),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .stall       (stall),
    .id_ex       (id_ex.source)
  );

  execute_stage execute (
    .clock        (clock),
    .reset        (reset),
    .id_ex        (id_ex.sink),
    .mem_fwd_en   (mem_fwd_en),
    .mem_fwd_rd   (mem_fwd_rd),
    .mem_fwd_data (mem_fwd_data),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .ex_mem       (ex_mem.source)
  );

  memory_stage memory (
    .clock        (clock),
    .reset        (reset),
    .ex_mem       (ex_mem.sink),
    .mem          (data_mem.requester),
    .mem_fwd_en   (mem_fwd_en),
    .mem_fwd_rd   (mem_fwd_rd),
    .mem_fwd_data (mem_fwd_data),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data)
  );

  mem_arbiter arbiter (
    .clock       (clock),
    .reset       (reset),
    .fetch_port  (fetch_mem.arbiter),
    .data_port   (data_mem.arbiter),
    .mem_addr    (mem_addr),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_data (mem_wr_data),
    .mem_rd_data (mem_rd_data)
  );

endmodule

/* tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Columns per test: name, program words from address 0, word stored at 0x100
localparam int NUM_TESTS = 4;
localparam int PROG_WORDS = 16;

string test_names [NUM_TESTS] = '{"alu_forward", "load_use", "branch_loop", "jal_link"};

localparam logic [31:0] PROGRAMS [NUM_TESTS][PROG_WORDS] = '{
  // addi x1,7; addi x2,-3; add x3; sub x4; slt x5; slti x6,x1,-1; xor x7
  // andi x8,0xff; or x9; xori x10,0xf0; add x11; addi x11,0x100; sw x11; jal self
  '{32'h0070_0093, 32'hffd0_0113, 32'h0020_81b3, 32'h4011_8233,
    32'h0032_22b3, 32'hfff0_a313, 32'h0012_43b3, 32'h0ff3_f413,
    32'h0054_64b3, 32'h0f04_c513, 32'h0065_05b3, 32'h1005_8593,
    32'h10b0_2023, 32'h0000_006f, 32'h0000_0000, 32'h0000_0000},
  // addi x1,0x200; addi x2,0x5a; sw x2,0(x1); lw x3,0(x1); addi x4,x3,1
  // add x5,x4,x3; sw x5; jal self
  '{32'h2000_0093, 32'h05a0_0113, 32'h0020_a023, 32'h0000_a183,
    32'h0011_8213, 32'h0032_02b3, 32'h1050_2023, 32'h0000_006f,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
  // addi x1,5; addi x2,0; loop: add x2,x2,x1; addi x1,-1; bne x1,x0,loop
  // beq x1,x0,+8; addi x2,0x40 (skipped); beq x2,x0,+8; addi x2,0x100; sw x2; jal self
  '{32'h0050_0093, 32'h0000_0113, 32'h0011_0133, 32'hfff0_8093,
    32'hfe00_9ce3, 32'h0000_8463, 32'h0401_0113, 32'h0001_0463,
    32'h1001_0113, 32'h1020_2023, 32'h0000_006f, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
  // addi x5,0x30; jal x1,+8; addi x5,0x77 (skipped); lui x5,1 (no-op)
  // add x6,x1,x5; sw x6; jal self
  '{32'h0300_0293, 32'h0080_00ef, 32'h0770_0293, 32'h0000_12b7,
    32'h0050_8333, 32'h1060_2023, 32'h0000_006f, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}
};

// Link value 8 plus 0x30 in the last test
localparam logic [31:0] EXPECTED [NUM_TESTS] = '{
  32'h0000_010b,
  32'h0000_00b5,
  32'h0000_010f,
  32'h0000_0038
};

`endif

/* tb_core.sv */
module tb_core import rv_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 400;
  localparam int MEM_WORDS = 1024;
  localparam word_t RESULT_ADDR = 32'h0000_0100;

  logic  clock = 1'b0;
  logic  reset = 1'b1;
  word_t mem_addr;
  logic  mem_rd_en;
  logic  mem_wr_en;
  word_t mem_wr_data;
  word_t mem_rd_data = '0;

  word_t mem [MEM_WORDS];
  word_t rd_word = '0;
  word_t req_addr;
  word_t req_wr_data;
  logic  req_rd;
  logic  req_wr;
  int    test_idx = 0;

  `include "tb_programs.svh"

  rv_core dut (
    .clock       (clock),
    .reset       (reset),
    .mem_addr    (mem_addr),
    .mem_rd_en   (mem_rd_en),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_data (mem_wr_data),
    .mem_rd_data (mem_rd_data)
  );

  always #2 clock = ~clock;

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what, input word_t expected,
                             input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_access();
    if ($isunknown({mem_rd_en, mem_wr_en})) begin
      $display("Memory enables are unknown out of reset");
      stop_on_error();
    end else if (mem_rd_en && mem_wr_en) begin
      $display("Read and write requested together at address %h", mem_addr);
      stop_on_error();
    end else if ((mem_rd_en || mem_wr_en) &&
                 (mem_addr[1:0] != 2'b00 || mem_addr[31:12] != '0)) begin
      $display("Memory access is unaligned or outside the model at address %h", mem_addr);
      stop_on_error();
    end
  endtask

  // Address-tagged fill, then the program from word 0
  task automatic load_program(input int idx);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hdead_0000 | word_t'(i * 4);
    end
    for (int w = 0; w < PROG_WORDS; w++) begin
      mem[w] = PROGRAMS[idx][w];
    end
  endtask

  // Requests sampled mid-cycle, where the DUT outputs have settled
  always @(negedge clock) begin
    req_addr = mem_addr;
    req_wr_data = mem_wr_data;
    req_rd = mem_rd_en;
    req_wr = mem_wr_en;
    if (!reset) begin
      check_access();
    end
  end

  // Writes at the edge, read data one cycle later
  always @(posedge clock) begin
    if (reset) begin
      load_program(test_idx);
    end else begin
      if (req_wr) begin
        mem[req_addr[11:2]] = req_wr_data;
      end
      if (req_rd) begin
        rd_word = mem[req_addr[11:2]];
      end
      #1 mem_rd_data = rd_word;
    end
  end

  task automatic run_program(input int idx);
    logic  found;
    word_t stored;
    found = 1'b0;
    stored = '0;
    @(posedge clock);
    #1;
    test_idx = idx;
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    // First cycle out of reset reads from the reset address
    @(negedge clock);
    check_value(test_names[idx], "first rd_en", 32'd1, word_t'(mem_rd_en));
    check_value(test_names[idx], "first addr", RESET_PC, mem_addr);
    check_value(test_names[idx], "first wr_en", 32'd0, word_t'(mem_wr_en));
    for (int cycle = 0; cycle < TIMEOUT_CYCLES && !found; cycle++) begin
      @(negedge clock);
      if (mem_wr_en && mem_addr == RESULT_ADDR) begin
        found = 1'b1;
        stored = mem_wr_data;
      end
    end
    if (!found) begin
      $display("Timeout: test %s made no store to address 100 within %0d cycles",
               test_names[idx], TIMEOUT_CYCLES);
      stop_on_error();
    end else begin
      check_value(test_names[idx], "result", EXPECTED[idx], stored);
    end
  endtask

  initial begin
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_program(t);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
rv_pkg.sv
mem_port_if.sv
pipe_if.sv
mem_arbiter.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_core.sv
tb_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_core -o tb_core
./obj_dir/tb_core
